// ==== cp0_defines.svh ====
`ifndef CP0_DEFINES_SVH
`define CP0_DEFINES_SVH

// CP0 register numbers
`define CP0_REG_COUNT    5'd9
`define CP0_REG_COMPARE  5'd11
`define CP0_REG_STATUS   5'd12
`define CP0_REG_CAUSE    5'd13
`define CP0_REG_EPC      5'd14
`define CP0_REG_PRID     5'd15
`define CP0_REG_CONFIG   5'd16

// reset and constant values
`define STATUS_RESET     32'h1000_0000    // CU0 set, interrupts off
`define CONFIG_VALUE     32'h0000_8000    // big endian, no MMU
`define PRID_VALUE       32'h004c_0102

// Cause.ExcCode values
`define EXC_INT          5'd0
`define EXC_SYS          5'd8
`define EXC_RI           5'd10
`define EXC_OV           5'd12

`define EXC_VECTOR       32'hbfc0_0380    // general exception entry, BEV=1

// Status bit positions
`define STATUS_IE        0
`define STATUS_EXL       1
`define STATUS_IM_LSB    8
`define STATUS_IM_MSB    15

// Cause bit positions
`define CAUSE_EXC_LSB    2
`define CAUSE_EXC_MSB    6
`define CAUSE_IP_LSB     8
`define CAUSE_IP_HW_LSB  10               // IP[7:2], hardware lines
`define CAUSE_IP_MSB     15
`define CAUSE_WP         22
`define CAUSE_IV         23

`endif

// ==== cp0_pkg.sv ====
`default_nettype none

package cp0_pkg;

    // plain vector types
    typedef logic [31:0] word_t;       // data word
    typedef logic [4:0]  cp0_addr_t;   // CP0 register number
    typedef logic [5:0]  hw_irq_t;     // external interrupt lines
    typedef logic [4:0]  exc_code_t;   // Cause.ExcCode

    // one mtc0 write, memory or write-back stage
    typedef struct packed {
        logic      we;
        cp0_addr_t addr;
        word_t     data;
    } cp0_wr_t;

    // memory-stage report toward the exception unit
    typedef struct packed {
        logic      valid;   // instruction present in mem stage
        logic      exc;     // synchronous exception flagged
        exc_code_t code;    // code for the flagged exception
        logic      eret;    // instruction is an eret
        word_t     pc;
    } exc_req_t;

    // register update ordered by the exception unit
    typedef struct packed {
        logic      take;    // save EPC, code, set EXL
        logic      eret;    // clear EXL
        exc_code_t code;
        word_t     epc;     // pc to save
    } exc_commit_t;

endpackage

`default_nettype wire

// ==== cp0_irq_sync.sv ====
`timescale 1ns/100ps
`default_nettype none

// brings the asynchronous interrupt lines into the clk domain
module cp0_irq_sync
    import cp0_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    reset_i,
    input  wire hw_irq_t irq_i,      // raw, asynchronous
    output hw_irq_t      irq_o       // synchronized
);

    hw_irq_t irq_meta;               // first stage, may go metastable

    always_ff @(posedge clk) begin
        if (reset_i) begin
            irq_meta <= '0;
        end else begin
            irq_meta <= irq_i;
        end
    end

    // second stage settles the level before anyone looks at it
    always_ff @(posedge clk) begin
        if (reset_i) begin
            irq_o <= '0;
        end else begin
            irq_o <= irq_meta;
        end
    end

endmodule

`default_nettype wire

// ==== cp0_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cp0_defines.svh"

module cp0_regs
    import cp0_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        reset_i,
    input  wire cp0_wr_t     mem_wr_i,     // mtc0 in memory stage, forwarding only
    input  wire cp0_wr_t     wb_wr_i,      // mtc0 in write-back stage
    input  wire cp0_addr_t   raddr_i,
    input  wire hw_irq_t     irq_i,        // already synchronized
    input  wire exc_commit_t commit_i,
    output word_t            rdata_o,
    output word_t            status_o,
    output word_t            cause_o,
    output word_t            epc_o,
    output word_t            epc_fwd_o,
    output logic             timer_int_o
);

    word_t count_q;
    word_t compare_q;
    word_t status_q;
    word_t cause_q;
    word_t epc_q;
    word_t rd_mux;                         // stored value at raddr_i
    logic  timer_hit;

    assign timer_hit = (compare_q != '0) && (compare_q == count_q);

    // register updates
    always_ff @(posedge clk) begin
        if (reset_i) begin
            count_q     <= '0;
            compare_q   <= '0;
            status_q    <= `STATUS_RESET;
            cause_q     <= '0;
            epc_q       <= '0;
            timer_int_o <= 1'b0;
        end else begin
            count_q <= count_q + 32'd1;    // free running
            if (timer_hit) begin
                timer_int_o <= 1'b1;       // held until Compare written
            end

            // hardware IP bits, timer folded onto IP7
            cause_q[`CAUSE_IP_MSB:`CAUSE_IP_HW_LSB] <= {irq_i[5] | timer_int_o, irq_i[4:0]};

            if (wb_wr_i.we) begin
                case (wb_wr_i.addr)
                    `CP0_REG_COUNT: begin
                        count_q <= wb_wr_i.data;
                    end
                    `CP0_REG_COMPARE: begin
                        compare_q   <= wb_wr_i.data;
                        timer_int_o <= 1'b0;   // acknowledge
                    end
                    `CP0_REG_STATUS: begin
                        status_q <= wb_wr_i.data;
                    end
                    `CP0_REG_CAUSE: begin
                        // software IP, WP and IV only
                        cause_q[`CAUSE_IP_HW_LSB-1:`CAUSE_IP_LSB] <=
                            wb_wr_i.data[`CAUSE_IP_HW_LSB-1:`CAUSE_IP_LSB];
                        cause_q[`CAUSE_WP] <= wb_wr_i.data[`CAUSE_WP];
                        cause_q[`CAUSE_IV] <= wb_wr_i.data[`CAUSE_IV];
                    end
                    `CP0_REG_EPC: begin
                        epc_q <= wb_wr_i.data;
                    end
                    default: begin
                    end
                endcase
            end

            // exception commit comes last so it wins over the mtc0
            if (commit_i.take) begin
                epc_q                                   <= commit_i.epc;
                cause_q[`CAUSE_EXC_MSB:`CAUSE_EXC_LSB]  <= commit_i.code;
                status_q[`STATUS_EXL]                   <= 1'b1;
            end else if (commit_i.eret) begin
                status_q[`STATUS_EXL] <= 1'b0;
            end
        end
    end

    // stored value lookup
    always_comb begin
        case (raddr_i)
            `CP0_REG_COUNT:   rd_mux = count_q;
            `CP0_REG_COMPARE: rd_mux = compare_q;
            `CP0_REG_STATUS:  rd_mux = status_q;
            `CP0_REG_CAUSE:   rd_mux = cause_q;
            `CP0_REG_EPC:     rd_mux = epc_q;
            `CP0_REG_PRID:    rd_mux = `PRID_VALUE;
            `CP0_REG_CONFIG:  rd_mux = `CONFIG_VALUE;
            default:          rd_mux = '0;     // unknown register
        endcase
    end

    // registered read, younger write wins
    always_ff @(posedge clk) begin
        if (reset_i) begin
            rdata_o <= '0;
        end else if (mem_wr_i.we && (mem_wr_i.addr == raddr_i)) begin
            rdata_o <= mem_wr_i.data;
        end else if (wb_wr_i.we && (wb_wr_i.addr == raddr_i)) begin
            rdata_o <= wb_wr_i.data;       // not yet in the register
        end else begin
            rdata_o <= rd_mux;
        end
    end

    // eret right behind an mtc0 EPC must see the new value
    always_comb begin
        if (wb_wr_i.we && (wb_wr_i.addr == `CP0_REG_EPC)) begin
            epc_fwd_o = wb_wr_i.data;
        end else begin
            epc_fwd_o = epc_q;
        end
    end

    assign status_o = status_q;
    assign cause_o  = cause_q;
    assign epc_o    = epc_q;

endmodule

`default_nettype wire

// ==== cp0_exception.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cp0_defines.svh"

module cp0_exception
    import cp0_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     reset_i,
    input  wire exc_req_t req_i,       // memory-stage report
    input  wire word_t    status_i,
    input  wire word_t    cause_i,
    input  wire word_t    epc_i,       // EPC with write-back bypass
    output exc_commit_t   commit_o,    // same cycle, to register file
    output logic          flush_o,
    output word_t         target_o
);

    logic [7:0] ip_masked;             // pending and enabled lines
    logic       exl;
    logic       int_pending;
    logic       exc_ok;
    word_t      next_target;

    assign exl       = status_i[`STATUS_EXL];
    assign ip_masked = cause_i[`CAUSE_IP_MSB:`CAUSE_IP_LSB] &
                       status_i[`STATUS_IM_MSB:`STATUS_IM_LSB];

    // interrupts need IE and no exception in progress
    assign int_pending = status_i[`STATUS_IE] && !exl && (|ip_masked);
    assign exc_ok      = req_i.exc && !exl;     // no nesting

    // decision, interrupt first, then exception, then eret
    always_comb begin
        commit_o      = '0;
        commit_o.epc  = req_i.pc;
        commit_o.code = `EXC_INT;
        if (req_i.valid) begin
            if (int_pending) begin
                commit_o.take = 1'b1;
            end else if (exc_ok) begin
                commit_o.take = 1'b1;
                commit_o.code = req_i.code;
            end else if (req_i.eret) begin
                commit_o.eret = 1'b1;
            end
        end
    end

    // eret returns through EPC, everything else to the vector
    assign next_target = commit_o.eret ? epc_i : `EXC_VECTOR;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            flush_o  <= 1'b0;
            target_o <= '0;
        end else begin
            flush_o  <= commit_o.take | commit_o.eret;   // one cycle pulse
            target_o <= next_target;
        end
    end

endmodule

`default_nettype wire

// ==== cp0_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module cp0_unit
    import cp0_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      reset_i,
    input  wire hw_irq_t   int_i,        // asynchronous lines
    input  wire cp0_wr_t   mem_wr_i,
    input  wire cp0_wr_t   wb_wr_i,
    input  wire cp0_addr_t raddr_i,
    input  wire exc_req_t  exc_req_i,
    output word_t          rdata_o,
    output logic           timer_int_o,
    output logic           flush_o,
    output word_t          target_o,
    output word_t          status_o,
    output word_t          cause_o,
    output word_t          epc_o
);

    hw_irq_t     irq_sync;
    word_t       status;
    word_t       cause;
    word_t       epc_fwd;
    exc_commit_t commit;

    cp0_irq_sync u_irq_sync (
        .clk     (clk),
        .reset_i (reset_i),
        .irq_i   (int_i),
        .irq_o   (irq_sync)
    );

    cp0_regs u_regs (
        .clk         (clk),
        .reset_i     (reset_i),
        .mem_wr_i    (mem_wr_i),
        .wb_wr_i     (wb_wr_i),
        .raddr_i     (raddr_i),
        .irq_i       (irq_sync),
        .commit_i    (commit),
        .rdata_o     (rdata_o),
        .status_o    (status),
        .cause_o     (cause),
        .epc_o       (epc_o),
        .epc_fwd_o   (epc_fwd),
        .timer_int_o (timer_int_o)
    );

    cp0_exception u_exception (
        .clk      (clk),
        .reset_i  (reset_i),
        .req_i    (exc_req_i),
        .status_i (status),
        .cause_i  (cause),
        .epc_i    (epc_fwd),
        .commit_o (commit),
        .flush_o  (flush_o),
        .target_o (target_o)
    );

    assign status_o = status;
    assign cause_o  = cause;

endmodule

`default_nettype wire

// ==== tb_cp0_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cp0_defines.svh"

module tb_cp0_unit
    import cp0_pkg::*;
();

    // one table row, expectations apply to the cycle after it is sampled
    typedef struct packed {
        hw_irq_t   irq;
        cp0_wr_t   mem;
        cp0_wr_t   wb;
        cp0_addr_t raddr;
        exc_req_t  req;
        word_t     exp_rdata;
        logic      exp_flush;
        word_t     exp_target;
        logic      exp_timer;
        logic      chk_rd;       // compare rdata_o
        logic      chk_tgt;      // compare target_o
        logic      use_model;    // rdata expectation from the model
    } row_t;

    logic      clk;
    logic      reset_i;
    hw_irq_t   int_i;
    cp0_wr_t   mem_wr_i;
    cp0_wr_t   wb_wr_i;
    cp0_addr_t raddr_i;
    exc_req_t  exc_req_i;
    word_t     rdata_o;
    logic      timer_int_o;
    logic      flush_o;
    word_t     target_o;
    word_t     status_o;
    word_t     cause_o;
    word_t     epc_o;

    row_t    table_q[$];
    row_t    cur;                // row under construction
    hw_irq_t irq_level;          // int_i level held across rows
    integer  seed = 21;
    int      errors = 0;
    int      checks = 0;
    int      cycles = 0;
    int      limit = 1000;

    // model state, value before the edge that samples the next row
    word_t m_count;
    word_t m_compare;
    word_t m_status;
    logic  m_timer;

    cp0_unit dut0 (
        .clk         (clk),
        .reset_i     (reset_i),
        .int_i       (int_i),
        .mem_wr_i    (mem_wr_i),
        .wb_wr_i     (wb_wr_i),
        .raddr_i     (raddr_i),
        .exc_req_i   (exc_req_i),
        .rdata_o     (rdata_o),
        .timer_int_o (timer_int_o),
        .flush_o     (flush_o),
        .target_o    (target_o),
        .status_o    (status_o),
        .cause_o     (cause_o),
        .epc_o       (epc_o)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > limit) begin
            $display("timeout: run still going after %0d cycles", cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input word_t exp, input word_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    function automatic cp0_wr_t make_wr(input cp0_addr_t addr, input word_t data);
        cp0_wr_t w;
        w.we   = 1'b1;
        w.addr = addr;
        w.data = data;
        return w;
    endfunction

    task automatic begin_row();
        cur     = '0;
        cur.irq = irq_level;
    endtask

    // fills model expectations, then advances the model by one edge
    task automatic push_row();
        word_t stored;
        logic  take;
        logic  eret;
        case (cur.raddr)
            `CP0_REG_COUNT:   stored = m_count;
            `CP0_REG_COMPARE: stored = m_compare;
            `CP0_REG_STATUS:  stored = m_status;
            default:          stored = '0;
        endcase
        if (cur.use_model) begin
            if (cur.mem.we && cur.mem.addr == cur.raddr) begin
                cur.exp_rdata = cur.mem.data;      // memory stage is youngest
            end else if (cur.wb.we && cur.wb.addr == cur.raddr) begin
                cur.exp_rdata = cur.wb.data;
            end else begin
                cur.exp_rdata = stored;
            end
        end
        take = cur.exp_flush && !cur.req.eret;
        eret = cur.exp_flush && cur.req.eret;
        if (cur.wb.we && cur.wb.addr == `CP0_REG_COMPARE) begin
            m_timer = 1'b0;
        end else if (m_compare != '0 && m_compare == m_count) begin
            m_timer = 1'b1;
        end
        if (cur.wb.we && cur.wb.addr == `CP0_REG_COUNT) begin
            m_count = cur.wb.data;
        end else begin
            m_count = m_count + 32'd1;
        end
        if (cur.wb.we && cur.wb.addr == `CP0_REG_COMPARE) begin
            m_compare = cur.wb.data;
        end
        if (cur.wb.we && cur.wb.addr == `CP0_REG_STATUS) begin
            m_status = cur.wb.data;
        end
        if (take) begin
            m_status[`STATUS_EXL] = 1'b1;
        end else if (eret) begin
            m_status[`STATUS_EXL] = 1'b0;
        end
        cur.exp_timer = m_timer;
        table_q.push_back(cur);
    endtask

    task automatic idle_row();
        begin_row();
        push_row();
    endtask

    task automatic write_row(input cp0_addr_t addr, input word_t data);
        begin_row();
        cur.wb = make_wr(addr, data);
        push_row();
    endtask

    task automatic read_row(input cp0_addr_t addr, input word_t exp);
        begin_row();
        cur.raddr     = addr;
        cur.exp_rdata = exp;
        cur.chk_rd    = 1'b1;
        push_row();
    endtask

    task automatic read_model_row(input cp0_addr_t addr);
        begin_row();
        cur.raddr     = addr;
        cur.chk_rd    = 1'b1;
        cur.use_model = 1'b1;
        push_row();
    endtask

    task automatic request_row(input logic exc, input exc_code_t code, input logic eret,
                               input word_t pc, input logic flush, input word_t target);
        begin_row();
        cur.req.valid  = 1'b1;
        cur.req.exc    = exc;
        cur.req.code   = code;
        cur.req.eret   = eret;
        cur.req.pc     = pc;
        cur.exp_flush  = flush;
        cur.exp_target = target;
        cur.chk_tgt    = flush;
        push_row();
    endtask

    task automatic build_table();
        word_t d_epc;
        word_t s_val;
        word_t c_val;
        word_t cv;
        word_t a_val;
        word_t b_val;
        word_t p1;
        word_t p2;
        word_t p3;
        word_t p4;
        word_t p5;
        word_t e2;
        m_count   = '0;
        m_compare = '0;
        m_status  = `STATUS_RESET;
        m_timer   = 1'b0;
        irq_level = '0;
        d_epc = $random(seed);
        s_val = ($random(seed) & 32'h0000_fc00) | `STATUS_RESET;  // IE and EXL stay clear
        c_val = $random(seed) | 32'h8000_0000;                    // far above Count
        cv    = $random(seed) & 32'h0fff_ff00;
        a_val = $random(seed);
        b_val = $random(seed);
        p1    = $random(seed);
        p2    = $random(seed);
        p3    = $random(seed);
        p4    = $random(seed);
        p5    = $random(seed);
        e2    = $random(seed);

        read_model_row(`CP0_REG_STATUS);
        read_row(`CP0_REG_CONFIG, `CONFIG_VALUE);
        read_row(`CP0_REG_PRID, `PRID_VALUE);

        write_row(`CP0_REG_EPC, d_epc);
        read_row(`CP0_REG_EPC, d_epc);
        write_row(`CP0_REG_STATUS, s_val);
        read_model_row(`CP0_REG_STATUS);
        write_row(`CP0_REG_COMPARE, c_val);
        read_model_row(`CP0_REG_COMPARE);
        write_row(`CP0_REG_CAUSE, 32'hffff_ffff);
        read_row(`CP0_REG_CAUSE, 32'h00c0_0300);     // only IP1:0, WP and IV stick
        begin_row();
        cur.wb     = make_wr(`CP0_REG_CAUSE, '0);
        cur.raddr  = 5'd3;                           // no such register
        cur.chk_rd = 1'b1;
        push_row();

        begin_row();
        cur.mem       = make_wr(`CP0_REG_EPC, a_val);
        cur.wb        = make_wr(`CP0_REG_EPC, b_val);
        cur.raddr     = `CP0_REG_EPC;
        cur.exp_rdata = a_val;                       // memory stage wins
        cur.chk_rd    = 1'b1;
        push_row();
        begin_row();
        cur.wb        = make_wr(`CP0_REG_EPC, a_val);
        cur.raddr     = `CP0_REG_EPC;
        cur.exp_rdata = a_val;
        cur.chk_rd    = 1'b1;
        push_row();
        read_row(`CP0_REG_EPC, a_val);

        write_row(`CP0_REG_COUNT, cv);
        read_model_row(`CP0_REG_COUNT);
        idle_row();
        read_model_row(`CP0_REG_COUNT);
        write_row(`CP0_REG_COMPARE, m_count + 32'd5);  // match a few edges ahead
        repeat (6) idle_row();
        read_row(`CP0_REG_CAUSE, 32'h0000_8000);     // timer shows on IP7
        idle_row();
        write_row(`CP0_REG_COMPARE, '0);

        request_row(1'b1, `EXC_SYS, 1'b0, p1, 1'b1, `EXC_VECTOR);
        read_row(`CP0_REG_EPC, p1);
        read_row(`CP0_REG_CAUSE, 32'h0000_0020);
        read_model_row(`CP0_REG_STATUS);
        request_row(1'b1, `EXC_OV, 1'b0, p2, 1'b0, '0);  // EXL blocks it
        read_row(`CP0_REG_EPC, p1);
        request_row(1'b0, '0, 1'b1, p2, 1'b1, p1);
        request_row(1'b1, `EXC_SYS, 1'b0, p3, 1'b1, `EXC_VECTOR);
        begin_row();
        cur.wb         = make_wr(`CP0_REG_EPC, e2);  // mtc0 just ahead of the eret
        cur.req.valid  = 1'b1;
        cur.req.eret   = 1'b1;
        cur.req.pc     = p3;
        cur.exp_flush  = 1'b1;
        cur.exp_target = e2;
        cur.chk_tgt    = 1'b1;
        push_row();
        read_model_row(`CP0_REG_STATUS);
        read_row(`CP0_REG_EPC, e2);

        write_row(`CP0_REG_STATUS, `STATUS_RESET | 32'h0000_0401);  // IE, IM2 only
        irq_level = 6'b000010;                       // drives IP3
        repeat (3) idle_row();
        read_row(`CP0_REG_CAUSE, 32'h0000_0820);
        request_row(1'b0, '0, 1'b0, p4, 1'b0, '0);   // IM3 clear
        write_row(`CP0_REG_STATUS, `STATUS_RESET | 32'h0000_0801);
        request_row(1'b0, '0, 1'b0, p5, 1'b1, `EXC_VECTOR);
        read_row(`CP0_REG_CAUSE, 32'h0000_0800);
        irq_level = '0;
        read_row(`CP0_REG_EPC, p5);
        read_model_row(`CP0_REG_STATUS);
        idle_row();
    endtask

    task automatic apply_row(input row_t r);
        int_i     <= r.irq;
        mem_wr_i  <= r.mem;
        wb_wr_i   <= r.wb;
        raddr_i   <= r.raddr;
        exc_req_i <= r.req;
    endtask

    task automatic check_row(input row_t r);
        check_value("flush_o", {31'b0, r.exp_flush}, {31'b0, flush_o});
        check_value("timer_int_o", {31'b0, r.exp_timer}, {31'b0, timer_int_o});
        if (r.chk_rd) begin
            check_value("rdata_o", r.exp_rdata, rdata_o);
        end
        // register outputs still hold the value just read
        if (r.chk_rd && !r.wb.we && !r.req.valid) begin
            case (r.raddr)
                `CP0_REG_STATUS: check_value("status_o", r.exp_rdata, status_o);
                `CP0_REG_CAUSE:  check_value("cause_o", r.exp_rdata, cause_o);
                `CP0_REG_EPC:    check_value("epc_o", r.exp_rdata, epc_o);
                default: begin
                end
            endcase
        end
        if (r.chk_tgt) begin
            check_value("target_o", r.exp_target, target_o);
        end
    endtask

    initial begin
        clk       = 1'b0;
        reset_i   = 1'b1;
        int_i     = '0;
        mem_wr_i  = '0;
        wb_wr_i   = '0;
        raddr_i   = '0;
        exc_req_i = '0;
        build_table();
        limit = table_q.size() + 50;
        repeat (4) @(posedge clk);
        reset_i <= 1'b0;
        for (int k = 0; k <= table_q.size(); k++) begin
            if (k < table_q.size()) begin
                apply_row(table_q[k]);
            end else begin
                apply_row('0);                       // drain the last row
            end
            if (k > 0) begin
                @(negedge clk);
                check_row(table_q[k-1]);
            end
            @(posedge clk);
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+.
cp0_pkg.sv
cp0_irq_sync.sv
cp0_regs.sv
cp0_exception.sv
cp0_unit.sv
tb_cp0_unit.sv
